/* Bender.yml */
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_req_if.sv
  - icache_decode.sv
  - icache_way_array.sv
  - icache_execute.sv
  - icache_result.sv
  - icache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_icache.sv

/* icache.f */
icache_pkg.sv
icache_req_if.sv
icache_decode.sv
icache_way_array.sv
icache_execute.sv
icache_result.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

/* icache_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_decode
    import icache_pkg::*;
#(
    parameter int  INDEX_W = INDEX_W_DEF,
    localparam int TAG_W   = tag_width(INDEX_W)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_accept,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic              i_req_uncached,
    input  logic              i_cacop_en,
    input  logic [1:0]        i_cacop_code,
    icache_req_if.dec         req
);

    logic [TAG_W-1:0]      in_tag;
    logic [INDEX_W-1:0]    in_index;
    logic [PAIR_SEL_W-1:0] in_pair_sel;
    logic                  in_misaligned;
    cacop_e                in_kind;

    assign in_tag      = i_req_addr[ADDR_W-1 -: TAG_W];
    assign in_index    = i_req_addr[LINE_OFF_W +: INDEX_W];
    assign in_pair_sel = i_req_addr[LINE_OFF_W-1 -: PAIR_SEL_W];

    // cache ops use bit 0 as way select, so no alignment check there
    assign in_misaligned = (i_req_addr[1:0] != 2'b00) && !i_cacop_en;

    always_comb begin
        case (i_cacop_code)
            2'd0:    in_kind = CACOP_IDX0;
            2'd2:    in_kind = CACOP_HIT;
            default: in_kind = CACOP_IDX1;    // 1, and 3 folded in
        endcase
    end

    // request buffer payload
    always_ff @(posedge clk) begin
        if (i_accept) begin
            req.tag        <= in_tag;
            req.index      <= in_index;
            req.pair_sel   <= in_pair_sel;
            req.pc         <= i_req_addr;
            req.cacop_kind <= in_kind;
        end
    end

    // request flags, decided once here
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.uncached   <= 1'b0;
            req.misaligned <= 1'b0;
            req.cacop      <= 1'b0;
        end else if (i_accept) begin
            req.uncached   <= i_req_uncached && !i_cacop_en && !in_misaligned;
            req.misaligned <= in_misaligned;
            req.cacop      <= i_cacop_en;
        end
    end

    assign req.accept   = i_accept;
    assign req.rd_index = i_accept ? in_index : req.index;   // arrays see the new set early

    // the FSM spends the cycle after a cache op in CACOP with ready low
    a_no_accept_over_cacop: assert property (
        @(posedge clk) disable iff (!rstn)
        i_accept && i_cacop_en |=> !i_accept
    ) else $error("request accepted while a cache op is pending");

endmodule

`default_nettype wire

/* icache_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_execute
    import icache_pkg::*;
#(
    parameter int  INDEX_W = INDEX_W_DEF,
    localparam int TAG_W   = tag_width(INDEX_W)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_req_valid,
    input  logic              i_cacop_en,
    icache_req_if.exe         req,
    output logic              o_req_ready,
    output logic              o_accept,
    output logic              o_mem_valid,
    input  logic              i_mem_ready,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic [7:0]        o_mem_len,
    input  logic [LINE_W-1:0] i_mem_data,
    output line_u             o_line,
    output logic              o_from_refill,
    output logic              o_resp_strobe,
    output logic              o_cacop_done
);

    localparam int SETS = 1 << INDEX_W;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_MISS   = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_CACOP  = 3'd4;

    logic [2:0]       state_q;
    logic [2:0]       state_d;
    logic [2:0]       accept_state;

    logic [1:0]       way_valid;
    logic [TAG_W-1:0] way_tag [2];
    line_u            way_line [2];
    logic [1:0]       raw_hit;
    logic [1:0]       wr_en;
    logic [1:0]       inval;
    logic [1:0]       cacop_way;

    logic             hit_way;
    logic             cached_hit;
    logic             lookup_done;
    logic             by_index;
    logic             victim;
    logic             refill_we;
    logic [SETS-1:0]  lru_q;      // way used last, per set
    line_u            ret_q;      // return buffer

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way_array #(
            .INDEX_W (INDEX_W)
        ) u_way (
            .clk        (clk),
            .rstn       (rstn),
            .i_rd_index (req.rd_index),
            .i_wr_en    (wr_en[w]),
            .i_wr_index (req.index),
            .i_wr_tag   (req.tag),
            .i_wr_line  (ret_q),
            .i_inval    (inval[w]),
            .o_valid    (way_valid[w]),
            .o_tag      (way_tag[w]),
            .o_line     (way_line[w])
        );

        assign raw_hit[w] = way_valid[w] && (way_tag[w] == req.tag);
    end

    assign hit_way     = raw_hit[1];
    assign cached_hit  = (|raw_hit) && !req.uncached;
    assign lookup_done = req.misaligned || cached_hit;   // answered without memory

    // handshake toward the pipeline
    assign o_req_ready = (state_q == S_IDLE) || (state_q == S_REFILL)
                       || (state_q == S_LOOKUP && lookup_done);
    assign o_accept    = i_req_valid && o_req_ready;
    assign accept_state = i_cacop_en ? S_CACOP : S_LOOKUP;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_REFILL: begin
                state_d = req.accept ? accept_state : S_IDLE;
            end
            S_LOOKUP: begin
                if (!lookup_done) begin
                    state_d = S_MISS;
                end else begin
                    state_d = req.accept ? accept_state : S_IDLE;
                end
            end
            S_MISS: begin
                if (i_mem_ready) begin
                    state_d = S_REFILL;
                end
            end
            S_CACOP: state_d = S_IDLE;    // one-cycle op, ready stays low
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // memory read port
    assign o_mem_valid = (state_q == S_MISS);
    assign o_mem_len   = req.uncached ? MEM_LEN_UNCACHED : MEM_LEN_LINE;
    assign o_mem_addr  = req.uncached ? {req.pc[ADDR_W-1:3], 3'b000}
                                      : {req.pc[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (o_mem_valid && i_mem_ready) begin
            ret_q.raw <= i_mem_data;
        end
    end

    // refill goes to the way not used last
    assign victim    = ~lru_q[req.index];
    assign refill_we = (state_q == S_REFILL) && !req.uncached;
    assign wr_en     = {refill_we && victim, refill_we && !victim};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (state_q == S_LOOKUP && !req.misaligned && cached_hit) begin
            lru_q[req.index] <= hit_way;
        end else if (refill_we) begin
            lru_q[req.index] <= victim;
        end
    end

    // cache ops: index kinds pick the way by pc bit 0, hit kind by tag match
    assign by_index  = (req.cacop_kind != CACOP_HIT);
    assign cacop_way = by_index ? {req.pc[0], !req.pc[0]} : raw_hit;
    assign inval     = (state_q == S_CACOP) ? cacop_way : 2'b00;
    assign o_cacop_done = (state_q == S_CACOP);

    // toward result
    assign o_from_refill = (state_q == S_REFILL);
    assign o_line        = o_from_refill ? ret_q : way_line[hit_way];
    assign o_resp_strobe = (state_q == S_LOOKUP && lookup_done) || o_from_refill;

    a_mem_addr_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr)
    ) else $error("memory request changed before ready");

    // refill or invalidate, never both ways of a set at once
    a_single_way_write: assert property (
        @(posedge clk) disable iff (!rstn)
        !((wr_en[0] || inval[0]) && (wr_en[1] || inval[1]))
    ) else $error("both ways written in one cycle");

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int ADDR_W      = 32;
    localparam int INDEX_W_DEF = 4;            // 16 sets per way
    localparam int LINE_OFF_W  = 6;            // 64-byte line
    localparam int PAIR_SEL_W  = 3;
    localparam int LINE_PAIRS  = 1 << PAIR_SEL_W;
    localparam int LINE_W      = 8 << LINE_OFF_W;

    // word at the lower address sits in bits [31:0]
    typedef logic [63:0] pair_t;

    // one refill beat, seen as raw bits or as fetch pairs
    typedef union packed {
        logic [LINE_W-1:0]      raw;
        pair_t [LINE_PAIRS-1:0] pairs;
    } line_u;

    typedef enum logic [1:0] {
        CACOP_IDX0 = 2'd0,
        CACOP_IDX1 = 2'd1,
        CACOP_HIT  = 2'd2
    } cacop_e;

    typedef logic [6:0] exc_code_t;

    localparam exc_code_t EXC_NONE = 7'd0;
    localparam exc_code_t EXC_ADEF = 7'd8;    // fetch address not word aligned

    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    localparam logic [7:0] MEM_LEN_LINE     = 8'd15;
    localparam logic [7:0] MEM_LEN_UNCACHED = 8'd1;

    // tag bits left over once index and line offset are taken
    function automatic int tag_width(input int index_w);
        return ADDR_W - index_w - LINE_OFF_W;
    endfunction

endpackage

`default_nettype wire

/* icache_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface icache_req_if
    import icache_pkg::*;
#(
    parameter int  INDEX_W = INDEX_W_DEF,
    localparam int TAG_W   = tag_width(INDEX_W)
);

    logic                  accept;        // request taken at the coming edge
    logic [INDEX_W-1:0]    rd_index;      // array read index, bypassed on accept
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [PAIR_SEL_W-1:0] pair_sel;
    logic [ADDR_W-1:0]     pc;
    logic                  uncached;
    logic                  misaligned;
    logic                  cacop;
    cacop_e                cacop_kind;

    modport dec (
        output accept, rd_index, tag, index, pair_sel, pc,
        output uncached, misaligned, cacop, cacop_kind
    );

    modport exe (
        input accept, rd_index, tag, index, pc,
        input uncached, misaligned, cacop_kind
    );

    modport res (
        input pair_sel, pc, uncached, misaligned, cacop
    );

endinterface

`default_nettype wire

/* icache_result.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_result
    import icache_pkg::*;
(
    icache_req_if.res         req,
    input  line_u             i_line,
    input  logic              i_from_refill,
    input  logic              i_resp_strobe,
    output logic              o_resp_valid,
    output pair_t             o_resp_data,
    output logic [ADDR_W-1:0] o_resp_pc,
    output exc_code_t         o_resp_exc
);

    pair_t fetched;

    always_comb begin
        if (i_from_refill && req.uncached) begin
            fetched = i_line.pairs[0];        // uncached beat carries only pair 0
        end else begin
            fetched = i_line.pairs[req.pair_sel];
        end
    end

    assign o_resp_valid = i_resp_strobe;
    assign o_resp_pc    = req.pc;
    assign o_resp_data  = req.misaligned ? {INST_NOP, INST_NOP} : fetched;
    assign o_resp_exc   = req.misaligned ? EXC_ADEF : EXC_NONE;

    // execute must never answer a cache op with fetch data
    always_comb begin
        a_no_resp_on_cacop: assert #0 (!(o_resp_valid === 1'b1 && req.cacop === 1'b1))
            else $error("fetch response during a cache op");
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_W = INDEX_W_DEF
) (
    input  logic              clk,
    input  logic              rstn,
    // fetch side
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic              i_req_uncached,
    input  logic              i_cacop_en,
    input  logic [1:0]        i_cacop_code,
    output logic              o_resp_valid,
    output pair_t             o_resp_data,
    output logic [ADDR_W-1:0] o_resp_pc,
    output exc_code_t         o_resp_exc,
    output logic              o_cacop_done,
    // memory side
    output logic              o_mem_valid,
    input  logic              i_mem_ready,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic [7:0]        o_mem_len,
    input  logic [LINE_W-1:0] i_mem_data
);

    logic  accept;
    line_u line;
    logic  from_refill;
    logic  resp_strobe;

    icache_req_if #(
        .INDEX_W (INDEX_W)
    ) req_bus ();

    icache_decode #(
        .INDEX_W (INDEX_W)
    ) u_decode (
        .clk            (clk),
        .rstn           (rstn),
        .i_accept       (accept),
        .i_req_addr     (i_req_addr),
        .i_req_uncached (i_req_uncached),
        .i_cacop_en     (i_cacop_en),
        .i_cacop_code   (i_cacop_code),
        .req            (req_bus.dec)
    );

    icache_execute #(
        .INDEX_W (INDEX_W)
    ) u_execute (
        .clk           (clk),
        .rstn          (rstn),
        .i_req_valid   (i_req_valid),
        .i_cacop_en    (i_cacop_en),
        .req           (req_bus.exe),
        .o_req_ready   (o_req_ready),
        .o_accept      (accept),
        .o_mem_valid   (o_mem_valid),
        .i_mem_ready   (i_mem_ready),
        .o_mem_addr    (o_mem_addr),
        .o_mem_len     (o_mem_len),
        .i_mem_data    (i_mem_data),
        .o_line        (line),
        .o_from_refill (from_refill),
        .o_resp_strobe (resp_strobe),
        .o_cacop_done  (o_cacop_done)
    );

    icache_result u_result (
        .req           (req_bus.res),
        .i_line        (line),
        .i_from_refill (from_refill),
        .i_resp_strobe (resp_strobe),
        .o_resp_valid  (o_resp_valid),
        .o_resp_data   (o_resp_data),
        .o_resp_pc     (o_resp_pc),
        .o_resp_exc    (o_resp_exc)
    );

endmodule

`default_nettype wire

/* icache_way_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_way_array
    import icache_pkg::*;
#(
    parameter int  INDEX_W = INDEX_W_DEF,
    localparam int TAG_W   = tag_width(INDEX_W)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [INDEX_W-1:0] i_rd_index,
    input  logic               i_wr_en,
    input  logic [INDEX_W-1:0] i_wr_index,
    input  logic [TAG_W-1:0]   i_wr_tag,
    input  line_u              i_wr_line,
    input  logic               i_inval,
    output logic               o_valid,
    output logic [TAG_W-1:0]   o_tag,
    output line_u              o_line
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_mem [SETS];
    line_u            line_mem [SETS];
    logic             same_set;

    assign same_set = (i_wr_index == i_rd_index);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_inval) begin
            valid_q[i_wr_index] <= 1'b0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
    end

    // read port, write-first so a fetch right behind its refill hits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else if (same_set && i_inval) begin
            o_valid <= 1'b0;
        end else if (same_set && i_wr_en) begin
            o_valid <= 1'b1;
        end else begin
            o_valid <= valid_q[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (same_set && i_wr_en) begin
            o_tag  <= i_wr_tag;
            o_line <= i_wr_line;
        end else begin
            o_tag  <= tag_mem[i_rd_index];
            o_line <= line_mem[i_rd_index];
        end
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
;

    localparam int WAIT_LIMIT = 50;
    localparam logic [1:0] NO_MEM = 2'd0;
    localparam logic [1:0] WITH_MEM = 2'd1;
    localparam logic [1:0] ANY_MEM = 2'd2;    // random fetch, hit or miss

    typedef struct packed {
        logic [31:0] addr;
        logic        uncached;
        logic        cacop_en;
        logic [1:0]  code;
        logic [1:0]  mem;
        exc_code_t   exc;
    } entry_t;

    logic clk, rstn;
    logic i_req_valid, o_req_ready, i_req_uncached, i_cacop_en, o_cacop_done;
    logic [31:0] i_req_addr, o_resp_pc, o_mem_addr;
    logic [1:0] i_cacop_code;
    logic o_resp_valid, o_mem_valid, i_mem_ready;
    pair_t o_resp_data;
    exc_code_t o_resp_exc;
    logic [7:0] o_mem_len;
    logic [LINE_W-1:0] i_mem_data;

    entry_t stim_q[$];
    integer seed;
    int errors, timeouts;

    icache_top #(.INDEX_W(4)) uut (
        .clk(clk), .rstn(rstn),
        .i_req_valid(i_req_valid), .o_req_ready(o_req_ready), .i_req_addr(i_req_addr),
        .i_req_uncached(i_req_uncached), .i_cacop_en(i_cacop_en),
        .i_cacop_code(i_cacop_code), .o_resp_valid(o_resp_valid),
        .o_resp_data(o_resp_data), .o_resp_pc(o_resp_pc), .o_resp_exc(o_resp_exc),
        .o_cacop_done(o_cacop_done), .o_mem_valid(o_mem_valid), .i_mem_ready(i_mem_ready),
        .o_mem_addr(o_mem_addr), .o_mem_len(o_mem_len), .i_mem_data(i_mem_data)
    );

    tb_mem_model #(.SEED(45219)) u_mem (
        .clk(clk), .rstn(rstn), .i_valid(o_mem_valid), .o_ready(i_mem_ready),
        .i_addr(o_mem_addr), .i_len(o_mem_len), .o_data(i_mem_data)
    );

    always #20 clk = ~clk;

    // data rule: word at byte address a is ~a, lower word in the low half
    function automatic pair_t pair_at(input logic [31:0] addr);
        logic [31:0] a8;
        a8 = {addr[31:3], 3'b000};
        return {~(a8 + 32'd4), ~a8};
    endfunction

    function automatic void add_entry(input logic [31:0] addr, input logic unc,
                                      input logic cop, input logic [1:0] code,
                                      input logic [1:0] mem, input exc_code_t exc);
        stim_q.push_back({addr, unc, cop, code, mem, exc});
    endfunction

    task automatic check_pair(input pair_t got, input pair_t exp, input logic [31:0] addr);
        if (got !== exp) begin
            $display("FAILED at %0t: pair for %h is %h, expected %h", $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_exc(input exc_code_t got, input exc_code_t exp,
                             input logic [31:0] addr);
        if (got !== exp) begin
            $display("FAILED at %0t: exception for %h is %0d, expected %0d",
                     $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: response pc is %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem_req(input logic [31:0] got_addr, input logic [7:0] got_len,
                                 input logic [31:0] exp_addr, input logic [7:0] exp_len);
        if (got_addr !== exp_addr || got_len !== exp_len) begin
            $display("FAILED at %0t: memory request %h len %0d, expected %h len %0d",
                     $time, got_addr, got_len, exp_addr, exp_len);
            errors++;
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic apply_entry(input entry_t e);
        int          cnt;
        logic        mem_seen;
        logic [31:0] seen_addr;
        logic [7:0]  seen_len;
        pair_t       exp_data;
        mem_seen  = 1'b0;
        seen_addr = '0;
        seen_len  = '0;
        i_req_valid = 1'b1;
        i_req_addr = e.addr;
        i_req_uncached = e.uncached;
        i_cacop_en = e.cacop_en;
        i_cacop_code = e.code;
        cnt = 0;
        while (o_req_ready !== 1'b1 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (o_req_ready !== 1'b1) begin
            $display("timeout: request for %h was never accepted", e.addr);
            timeouts++;
            return;
        end
        @(negedge clk);    // cycle after acceptance
        i_req_valid = 1'b0;
        i_cacop_en = 1'b0;
        if (e.cacop_en) begin
            if (o_cacop_done !== 1'b1 || o_resp_valid !== 1'b0) begin
                $display("FAILED at %0t: cache op at %h gave no clean done pulse",
                         $time, e.addr);
                errors++;
            end
            return;
        end
        if (e.mem == NO_MEM && o_resp_valid !== 1'b1) begin
            $display("FAILED at %0t: no response for %h in the cycle after acceptance",
                     $time, e.addr);
            errors++;
            return;
        end
        cnt = 0;
        while (o_resp_valid !== 1'b1 && cnt < WAIT_LIMIT) begin
            if (o_mem_valid === 1'b1 && !mem_seen) begin
                mem_seen  = 1'b1;
                seen_addr = o_mem_addr;
                seen_len  = o_mem_len;
            end
            @(negedge clk);
            cnt++;
        end
        if (o_resp_valid !== 1'b1) begin
            $display("timeout: no response for %h", e.addr);
            timeouts++;
            return;
        end
        if (e.mem == WITH_MEM && !mem_seen) begin
            $display("FAILED at %0t: no memory request for %h", $time, e.addr);
            errors++;
        end
        if (mem_seen) begin
            check_mem_req(seen_addr, seen_len,
                          e.uncached ? {e.addr[31:3], 3'b000} : {e.addr[31:6], 6'b0},
                          e.uncached ? MEM_LEN_UNCACHED : MEM_LEN_LINE);
        end
        exp_data = (e.exc == EXC_ADEF) ? {INST_NOP, INST_NOP} : pair_at(e.addr);
        check_pair(o_resp_data, exp_data, e.addr);
        check_exc(o_resp_exc, e.exc, e.addr);
        check_pc(o_resp_pc, e.addr);
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr = '0;
        i_req_uncached = 1'b0;
        i_cacop_en = 1'b0;
        i_cacop_code = '0;
        errors = 0;
        timeouts = 0;
        seed = 45219;
        add_entry(32'h0000_0448, 0, 0, 0, WITH_MEM, EXC_NONE);   // miss, then hit
        add_entry(32'h0000_0470, 0, 0, 0, NO_MEM, EXC_NONE);
        add_entry(32'h0000_1088, 0, 0, 0, WITH_MEM, EXC_NONE);   // A, set 2
        add_entry(32'h0000_20a0, 0, 0, 0, WITH_MEM, EXC_NONE);   // B
        add_entry(32'h0000_1090, 0, 0, 0, NO_MEM, EXC_NONE);     // A hits
        add_entry(32'h0000_3080, 0, 0, 0, WITH_MEM, EXC_NONE);   // C evicts B
        add_entry(32'h0000_10b8, 0, 0, 0, NO_MEM, EXC_NONE);
        add_entry(32'h0000_2088, 0, 0, 0, WITH_MEM, EXC_NONE);   // B misses again
        add_entry(32'h0000_0448, 1, 0, 0, WITH_MEM, EXC_NONE);   // uncached, line is cached
        add_entry(32'h0000_044c, 1, 0, 0, WITH_MEM, EXC_NONE);
        add_entry(32'h0000_5000, 1, 0, 0, WITH_MEM, EXC_NONE);
        add_entry(32'h0000_5000, 0, 0, 0, WITH_MEM, EXC_NONE);   // uncached never allocates
        add_entry(32'h0000_0452, 0, 0, 0, NO_MEM, EXC_ADEF);
        add_entry(32'h0000_1081, 0, 0, 0, NO_MEM, EXC_ADEF);
        add_entry(32'h0000_2086, 1, 0, 0, NO_MEM, EXC_ADEF);
        add_entry(32'h0000_0441, 0, 1, 0, NO_MEM, EXC_NONE);     // index inval, set 1 way 1
        add_entry(32'h0000_0458, 0, 0, 0, WITH_MEM, EXC_NONE);
        add_entry(32'h0000_0440, 0, 1, 2, NO_MEM, EXC_NONE);     // hit inval
        add_entry(32'h0000_0440, 0, 0, 0, WITH_MEM, EXC_NONE);
        add_entry(32'h0000_1081, 0, 1, 1, NO_MEM, EXC_NONE);     // drops A from way 1
        add_entry(32'h0000_10a8, 0, 0, 0, WITH_MEM, EXC_NONE);
        add_entry(32'h0000_2098, 0, 0, 0, NO_MEM, EXC_NONE);     // B still in way 0
        for (int i = 0; i < 40; i++) begin
            add_entry(32'h0001_0000 | ($random(seed) & 32'h0000_0cf8), 0, 0, 0,
                      ANY_MEM, EXC_NONE);   // sets 0 to 3, four tags
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
            if (timeouts != 0) begin
                break;
            end
        end
        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
    import icache_pkg::*;
#(
    parameter int SEED = 45219
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_valid,
    output logic              o_ready,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [7:0]        i_len,
    output logic [LINE_W-1:0] o_data
);

    integer            seed = SEED;
    int                wait_left = 0;
    logic              busy = 1'b0;
    logic              ready_q = 1'b0;
    logic [LINE_W-1:0] data_q = '0;

    assign o_ready = ready_q;
    assign o_data  = data_q;

    // word at byte address a reads as ~a, len + 1 words from the request address
    function automatic logic [LINE_W-1:0] beat_for(input logic [ADDR_W-1:0] addr,
                                                   input logic [7:0] len);
        logic [LINE_W-1:0] beat;
        int                words;
        beat  = '0;
        words = (int'(len) + 1 > 16) ? 16 : int'(len) + 1;
        for (int i = 0; i < words; i++) begin
            beat[32*i +: 32] = ~(addr + 32'(4 * i));
        end
        return beat;
    endfunction

    // ready is held for one rising edge, then dropped
    always @(negedge clk) begin
        if (!rstn || ready_q) begin
            ready_q <= 1'b0;
            busy = 1'b0;
        end else if (i_valid) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = $unsigned($random(seed)) % 6;   // 0 to 5 cycles
            end
            if (wait_left == 0) begin
                ready_q <= 1'b1;
                data_q  <= beat_for(i_addr, i_len);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire
